//--- logic/bus_pkg.sv
// request bus definitions
`default_nettype none

package bus_pkg;

    // page decode in the address map assumes a 32-bit word
    localparam int addr_w = 32;

    typedef logic [addr_w-1:0] addr_t;   // byte address of a request

endpackage

`default_nettype wire

//--- logic/remap_map_pkg.sv
// address map definitions
`default_nettype none

package remap_map_pkg;
    import bus_pkg::*;

    localparam int num_windows = 4;
    localparam int page_w      = 4;   // upper nibble picks the window

    // one remap window, size in bytes
    typedef struct packed {
        addr_t base;
        addr_t size;
        addr_t dest;
    } remap_window_t;

    // same address word, flat for arithmetic or split for window select
    typedef union packed {
        addr_t flat;
        struct packed {
            logic [page_w-1:0]        page;
            logic [addr_w-page_w-1:0] offset;
        } pg;
    } addr_word_u;

    // page n+1 lands in window n
    localparam remap_window_t default_windows [num_windows] = '{
        '{base: 32'h1000_0000, size: 32'h0001_0000, dest: 32'h2000_0000},
        '{base: 32'h2000_0000, size: 32'h0001_0000, dest: 32'h3000_0000},
        '{base: 32'h3000_0000, size: 32'h0001_0000, dest: 32'h4000_0000},
        '{base: 32'h4000_0000, size: 32'h0001_0000, dest: 32'h5000_0000}
    };

endpackage

`default_nettype wire

//--- logic/bus_req_if.sv
// single beat request channel
`default_nettype none
`timescale 1ns/100ps

interface bus_req_if #(
    parameter int DATA_W = 32
);
    import bus_pkg::*;

    addr_t             addr;
    logic [DATA_W-1:0] data;
    logic              write;   // 1 = write, 0 = read
    logic              valid;
    logic              ready;

    modport initiator (
        output addr, data, write, valid,
        input  ready
    );

    modport target (
        input  addr, data, write, valid,
        output ready
    );

endinterface

`default_nettype wire

//--- logic/remap_table.sv
// address window lookup
`default_nettype none
`timescale 1ns/100ps

module remap_table #(
    parameter remap_map_pkg::remap_window_t WINDOWS [remap_map_pkg::num_windows] =
        remap_map_pkg::default_windows
) (
    input  bus_pkg::addr_t addr,
    output bus_pkg::addr_t remapped,
    output logic           hit
);
    import bus_pkg::*;
    import remap_map_pkg::*;

    localparam int sel_w = $clog2(num_windows);

    addr_word_u       word;
    remap_window_t    win;
    logic             page_hit;
    logic [sel_w-1:0] sel;
    logic [addr_w:0]  win_end;   // extra bit so base + size cannot wrap
    logic             in_range;

    always_comb begin
        word.flat = addr;

        // only pages 1..num_windows have a candidate window
        page_hit = (word.pg.page >= page_w'(1)) &&
                   (word.pg.page <= page_w'(num_windows));
        sel      = sel_w'(word.pg.page - page_w'(1));
        win      = WINDOWS[sel];

        win_end  = {1'b0, win.base} + {1'b0, win.size};
        in_range = (word.flat >= win.base) && ({1'b0, word.flat} < win_end);
        hit      = page_hit && in_range;

        if (hit) begin
            remapped = win.dest + (word.flat - win.base);   // dest + offset
        end else begin
            remapped = word.flat;
        end
    end

endmodule

`default_nettype wire

//--- logic/remap_bridge.sv
// remapping request stage
`default_nettype none
`timescale 1ns/100ps

module remap_bridge #(
    parameter int DATA_W = 32,
    parameter remap_map_pkg::remap_window_t WINDOWS [remap_map_pkg::num_windows] =
        remap_map_pkg::default_windows
) (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::addr_t    in_addr,
    input  logic [DATA_W-1:0] in_data,
    input  logic              in_valid,
    input  logic              in_write,
    output logic              in_ready,
    bus_req_if.initiator      down
);
    import bus_pkg::*;

    logic              busy;       // 0 = idle, 1 = holding a request
    addr_t             map_addr;
    logic              map_hit;
    addr_t             cap_addr;
    logic [DATA_W-1:0] cap_data;
    logic              cap_write;

    remap_table #(
        .WINDOWS (WINDOWS)
    ) u_table (
        .addr     (in_addr),
        .remapped (map_addr),
        .hit      (map_hit)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            cap_addr  <= '0;
            cap_data  <= '0;
            cap_write <= 1'b0;
        end else if (!busy) begin
            if (in_valid) begin
                busy      <= 1'b1;
                cap_addr  <= map_hit ? map_addr : in_addr;
                cap_data  <= in_data;
                cap_write <= in_write;
            end
        end else if (down.ready) begin
            busy <= 1'b0;   // handed to the queue this edge
        end
    end

    // at most one request every two cycles
    assign in_ready   = !busy;
    assign down.valid = busy;
    assign down.addr  = cap_addr;
    assign down.data  = cap_data;
    assign down.write = cap_write;

endmodule

`default_nettype wire

//--- logic/req_fifo.sv
// show-ahead request queue
`default_nettype none
`timescale 1ns/100ps

module req_fifo #(
    parameter int DATA_W     = 32,
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    bus_req_if.target         up,
    output bus_pkg::addr_t    out_addr,
    output logic [DATA_W-1:0] out_data,
    output logic              out_write,
    output logic              out_valid,
    input  logic              out_ready
);
    import bus_pkg::*;

    // depth is a power of two, pointers wrap on their own
    localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    addr_t             addr_mem  [FIFO_DEPTH];
    logic [DATA_W-1:0] data_mem  [FIFO_DEPTH];
    logic              write_mem [FIFO_DEPTH];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [ptr_w:0]    count;
    logic              push;
    logic              pop;

    assign up.ready  = (count != (ptr_w+1)'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign push      = up.valid && up.ready;
    assign pop       = out_valid && out_ready;

    // entries cleared so the outputs read zero out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < FIFO_DEPTH; i++) begin
                addr_mem[i]  <= '0;
                data_mem[i]  <= '0;
                write_mem[i] <= 1'b0;
            end
        end else if (push) begin
            addr_mem[wr_ptr]  <= up.addr;
            data_mem[wr_ptr]  <= up.data;
            write_mem[wr_ptr] <= up.write;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign out_addr  = addr_mem[rd_ptr];   // head entry, no read latency
    assign out_data  = data_mem[rd_ptr];
    assign out_write = write_mem[rd_ptr];

endmodule

`default_nettype wire

//--- logic/remap_top.sv
// remapping request bridge
`default_nettype none
`timescale 1ns/100ps

module remap_top #(
    parameter int DATA_W     = 32,
    parameter int FIFO_DEPTH = 4,
    parameter remap_map_pkg::remap_window_t WINDOWS [remap_map_pkg::num_windows] =
        remap_map_pkg::default_windows
) (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::addr_t    in_addr,
    input  logic [DATA_W-1:0] in_data,
    input  logic              in_valid,
    input  logic              in_write,
    output logic              in_ready,
    output bus_pkg::addr_t    out_addr,
    output logic [DATA_W-1:0] out_data,
    output logic              out_valid,
    output logic              out_write,
    input  logic              out_ready
);

    bus_req_if #(
        .DATA_W (DATA_W)
    ) req_bus ();

    remap_bridge #(
        .DATA_W  (DATA_W),
        .WINDOWS (WINDOWS)
    ) u_bridge (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_addr  (in_addr),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_write (in_write),
        .in_ready (in_ready),
        .down     (req_bus.initiator)
    );

    // queue absorbs downstream stalls
    req_fifo #(
        .DATA_W     (DATA_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .up        (req_bus.target),
        .out_addr  (out_addr),
        .out_data  (out_data),
        .out_write (out_write),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

//--- tests/remap_tb.sv
// remap bridge testbench
`default_nettype none
`timescale 1ns/100ps

module remap_tb;
    import bus_pkg::*;
    import remap_map_pkg::*;

    localparam int data_w         = 32;
    localparam int fifo_depth     = 4;
    localparam int mix_count      = 200;
    localparam int total_reqs     = 260;   // request count of all tests rounded up
    localparam int timeout_cycles = total_reqs * 20 + 500;

    typedef struct packed {
        addr_t             addr;
        logic [data_w-1:0] data;
        logic              write;
    } req_t;

    logic              clk;
    logic              rst_n;
    addr_t             in_addr;
    logic [data_w-1:0] in_data;
    logic              in_valid;
    logic              in_write;
    logic              in_ready;
    addr_t             out_addr;
    logic [data_w-1:0] out_data;
    logic              out_valid;
    logic              out_write;
    logic              out_ready;

    req_t        exp_q [$];
    logic [31:0] rnd_state;
    int          err_count;
    int          test_err_start;
    int          pass_count;
    int          fail_count;
    int          out_count;

    remap_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_addr   (in_addr),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_write  (in_write),
        .in_ready  (in_ready),
        .out_addr  (out_addr),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_write (out_write),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rnd_state = xorshift(rnd_state);
        return rnd_state;
    endfunction

    // page n+1 goes to window n if the full address is in its range
    function automatic addr_t expected_addr(input addr_t a);
        addr_word_u    w;
        remap_window_t win;
        addr_t         res;
        w.flat = a;
        res    = a;
        for (int i = 0; i < num_windows; i++) begin
            win = default_windows[i];
            if (w.pg.page == 4'(i + 1) && a >= win.base && (a - win.base) < win.size) begin
                res = win.dest + (a - win.base);
            end
        end
        return res;
    endfunction

    // both handshakes are stable half a cycle before the edge they fire on
    always @(negedge clk) begin : scoreboard
        req_t e;
        req_t got;
        if (rst_n) begin
            if (in_valid && in_ready) begin
                e.addr  = expected_addr(in_addr);
                e.data  = in_data;
                e.write = in_write;
                exp_q.push_back(e);
            end
            if (out_valid && out_ready) begin
                out_count++;
                if (exp_q.size() == 0) begin
                    $display("at %0t an output request appeared that was never sent", $time);
                    err_count++;
                end else begin
                    got = exp_q.pop_front();
                    if (out_addr !== got.addr) begin
                        $display("CHECK FAILED at %0t: out_addr expected %h actual %h",
                                 $time, got.addr, out_addr);
                        err_count++;
                    end
                    if (out_data !== got.data) begin
                        $display("CHECK FAILED at %0t: out_data expected %h actual %h",
                                 $time, got.data, out_data);
                        err_count++;
                    end
                    if (out_write !== got.write) begin
                        $display("CHECK FAILED at %0t: out_write expected %b actual %b",
                                 $time, got.write, out_write);
                        err_count++;
                    end
                end
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic send_req(input addr_t addr, input logic [data_w-1:0] data,
                            input logic write);
        logic accepted;
        int   waited;
        in_addr  = addr;
        in_data  = data;
        in_write = write;
        in_valid = 1'b1;
        accepted = 1'b0;
        waited   = 0;
        while (!accepted && waited < 50) begin
            accepted = in_ready;   // in_ready only moves on the edge
            next_cycle();
            waited++;
        end
        in_valid = 1'b0;
        if (!accepted) begin
            $display("request to %h was never accepted", addr);
            err_count++;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 100) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d requests never came out of the bridge", exp_q.size());
            err_count++;
            exp_q.delete();
        end
    endtask

    task automatic finish_test(input string name);
        if (err_count == test_err_start) begin
            pass_count++;
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: FAIL, %0d errors", name, err_count - test_err_start);
        end
        test_err_start = err_count;
    endtask

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("watchdog: run still going after %0d cycles", timeout_cycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin : stimulus
        remap_window_t win;
        logic [31:0]   r;
        addr_t         a;
        int            accepted_n;
        int            low_run;
        int            sent;
        int            start_out;
        logic          offering;
        logic          accepted;

        rst_n          = 1'b0;
        in_addr        = '0;
        in_data        = '0;
        in_valid       = 1'b0;
        in_write       = 1'b0;
        out_ready      = 1'b1;
        rnd_state      = 32'hce2c;
        err_count      = 0;
        test_err_start = 0;
        pass_count     = 0;
        fail_count     = 0;
        out_count      = 0;

        // test 1 watches the reset state for 10 cycles and a few idle ones after
        for (int c = 0; c < 13; c++) begin
            next_cycle();
            if (c == 9) begin
                rst_n = 1'b1;
            end
            if (out_valid !== 1'b0) begin
                $display("CHECK FAILED at %0t: out_valid expected 0 actual %b", $time, out_valid);
                err_count++;
            end
            if (in_ready !== 1'b1) begin
                $display("CHECK FAILED at %0t: in_ready expected 1 actual %b", $time, in_ready);
                err_count++;
            end
            if (out_addr !== '0) begin
                $display("CHECK FAILED at %0t: out_addr expected 0 actual %h", $time, out_addr);
                err_count++;
            end
        end
        finish_test("reset");

        // test 2 hits the first byte, the last byte and a random offset
        for (int w = 0; w < num_windows; w++) begin
            win = default_windows[w];
            r = rand_word();
            send_req(win.base, rand_word(), r[0]);
            send_req(win.base + win.size - 1, rand_word(), r[1]);
            send_req(win.base + (r % win.size), rand_word(), r[2]);
        end
        wait_drain();
        finish_test("window hits");

        // test 3 misses in pages 1..4 and then page 0 and pages 5..F
        for (int w = 0; w < num_windows; w++) begin
            win = default_windows[w];
            r = rand_word();
            send_req(win.base + win.size, rand_word(), r[0]);
            send_req(win.base + win.size + {16'h0, r[31:16]}, rand_word(), r[1]);
        end
        for (int p = 0; p < 16; p++) begin
            if (p == 0 || p > num_windows) begin
                r = rand_word();
                send_req({4'(p), r[27:0]}, rand_word(), r[28]);
            end
        end
        r = rand_word();
        send_req({4'h0, r[27:0]}, rand_word(), r[29]);
        wait_drain();
        finish_test("pass through");

        // test 4 sends random reads and writes anywhere in the map
        for (int i = 0; i < 16; i++) begin
            r = rand_word();
            send_req(rand_word(), rand_word(), r[0]);
        end
        wait_drain();
        finish_test("data and write flag");

        // test 5 stalls the output and fills queue plus bridge
        out_ready  = 1'b0;
        accepted_n = 0;
        low_run    = 0;
        start_out  = out_count;
        while (low_run < 10 && accepted_n < 20) begin
            if (in_ready) begin
                r        = rand_word();
                in_addr  = r;
                in_data  = rand_word();
                in_write = r[0];
                in_valid = 1'b1;
                accepted_n++;
                low_run  = 0;
            end else begin
                in_valid = 1'b0;
                low_run++;
            end
            next_cycle();
        end
        in_valid = 1'b0;
        if (accepted_n != fifo_depth + 1) begin
            $display("stalled output absorbed %0d requests instead of %0d",
                     accepted_n, fifo_depth + 1);
            err_count++;
        end
        out_ready = 1'b1;
        wait_drain();
        if (out_count - start_out != accepted_n) begin
            $display("after the stall %0d requests came out, %0d went in",
                     out_count - start_out, accepted_n);
            err_count++;
        end
        finish_test("back pressure");

        // test 6 runs random traffic on both sides
        sent      = 0;
        offering  = 1'b0;
        start_out = out_count;
        while (sent < mix_count) begin
            r = rand_word();
            out_ready = (r[1:0] != 2'b00);
            if (!offering && r[3:2] != 2'b00) begin
                a = rand_word();
                if (r[4]) begin
                    win = default_windows[r[6:5]];
                    a   = win.base + (a % win.size);
                end
                in_addr  = a;
                in_data  = rand_word();
                in_write = r[7];
                in_valid = 1'b1;
                offering = 1'b1;
            end
            accepted = offering && in_ready;
            next_cycle();
            if (accepted) begin
                offering = 1'b0;
                in_valid = 1'b0;
                sent++;
            end
        end
        out_ready = 1'b1;
        wait_drain();
        if (out_count - start_out != mix_count) begin
            $display("random mix sent %0d requests and received %0d",
                     mix_count, out_count - start_out);
            err_count++;
        end
        finish_test("random mix");

        $display("tests passed: %0d  tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
logic/bus_pkg.sv
logic/remap_map_pkg.sv
logic/bus_req_if.sv
logic/remap_table.sv
logic/remap_bridge.sv
logic/req_fifo.sv
logic/remap_top.sv
tests/remap_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the remap bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    --timescale 1ns/100ps \
    --top-module remap_tb \
    -Mdir obj_dir \
    -f sources.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/Vremap_tb)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$sim_out" | grep -qx "All tests passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
